//--- lite_demux_pkg.sv
/*
  Shared AXI4-Lite types for the demux.
  Address and data are fixed at 32 bits. A port select is 2 bits wide,
  so the demux can serve at most 4 downstream ports.
*/
`default_nettype none

package lite_demux_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned ProtWidth = 3;
  localparam int unsigned SelWidth  = 2;

  typedef logic [SelWidth-1:0] port_sel_t;
  typedef logic [1:0]          resp_t;

  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespSlvErr = 2'b10;

  // ----------------------------------------
  // channel payloads
  // ----------------------------------------
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [ProtWidth-1:0] prot;
  } aw_chan_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
  } w_chan_t;

  typedef struct packed {
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [ProtWidth-1:0] prot;
  } ar_chan_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    resp_t                resp;
  } r_chan_t;

  // ----------------------------------------
  // full bus bundles
  // ----------------------------------------
  // manager to subordinate direction
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } lite_req_t;

  // subordinate to manager direction
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } lite_resp_t;

endpackage

`default_nettype wire

//--- select_fifo.sv
/*
  Small synchronous FIFO of port selects.
  Not fall-through: a pushed entry shows on data_o one cycle later.
  A push while full or a pop while empty is ignored.
  data_o is only meaningful while empty_o is low.
*/
`default_nettype none

module select_fifo #(
  parameter int unsigned Depth = 4
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      push_i,
  input  lite_demux_pkg::port_sel_t data_i,
  input  logic                      pop_i,
  output lite_demux_pkg::port_sel_t data_o,
  output logic                      full_o,
  output logic                      empty_o
);
  import lite_demux_pkg::*;

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  port_sel_t           mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                do_push;
  logic                do_pop;

  assign full_o  = (count_q == CntWidth'(Depth));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  // storage, no reset needed
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- demux_write_path.sv
/*
  Write half of the AXI4-Lite demux: AW, W and B.
  aw_select_i must stay stable with aw_valid_i until aw_ready_o.
  Up to MaxTrans writes may be open; W and B follow AW issue order.
  Selects at or above NumPorts are not supported.
*/
`default_nettype none

module demux_write_path #(
  parameter int unsigned NumPorts = 3,
  parameter int unsigned MaxTrans = 4
) (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  // upstream
  input  lite_demux_pkg::aw_chan_t                 aw_i,
  input  logic                                     aw_valid_i,
  input  lite_demux_pkg::port_sel_t                aw_select_i,
  output logic                                     aw_ready_o,
  input  lite_demux_pkg::w_chan_t                  w_i,
  input  logic                                     w_valid_i,
  output logic                                     w_ready_o,
  output lite_demux_pkg::b_chan_t                  b_o,
  output logic                                     b_valid_o,
  input  logic                                     b_ready_i,
  // downstream
  output lite_demux_pkg::aw_chan_t [NumPorts-1:0]  mst_aw_o,
  output logic [NumPorts-1:0]                      mst_aw_valid_o,
  input  logic [NumPorts-1:0]                      mst_aw_ready_i,
  output lite_demux_pkg::w_chan_t [NumPorts-1:0]   mst_w_o,
  output logic [NumPorts-1:0]                      mst_w_valid_o,
  input  logic [NumPorts-1:0]                      mst_w_ready_i,
  input  lite_demux_pkg::b_chan_t [NumPorts-1:0]   mst_b_i,
  input  logic [NumPorts-1:0]                      mst_b_valid_i,
  output logic [NumPorts-1:0]                      mst_b_ready_o
);
  import lite_demux_pkg::*;

  logic                aw_lock_q;
  logic                aw_offer;
  logic [NumPorts-1:0] aw_port_hit;

  logic                w_fifo_push;
  logic                w_fifo_pop;
  logic                w_fifo_full;
  logic                w_fifo_empty;
  port_sel_t           w_select;
  logic                w_route_ok;
  logic [NumPorts-1:0] w_port_hit;

  logic                b_fifo_pop;
  logic                b_fifo_full;
  logic                b_fifo_empty;
  port_sel_t           b_select;
  logic [NumPorts-1:0] b_port_hit;

  // ----------------------------------------
  // AW channel
  // ----------------------------------------
  // a fresh AW is only offered when its select fits in the W FIFO,
  // a locked one stays offered until the port takes it
  assign aw_offer    = aw_lock_q | (aw_valid_i & ~w_fifo_full);
  assign w_fifo_push = ~aw_lock_q & aw_valid_i & ~w_fifo_full;
  assign aw_ready_o  = |(mst_aw_valid_o & mst_aw_ready_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_lock_q <= 1'b0;
    end else begin
      aw_lock_q <= aw_offer & ~aw_ready_o;
    end
  end

  // ----------------------------------------
  // per-port steering
  // ----------------------------------------
  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    assign aw_port_hit[p] = (aw_select_i == port_sel_t'(p));
    assign w_port_hit[p]  = (w_select == port_sel_t'(p));
    assign b_port_hit[p]  = (b_select == port_sel_t'(p));

    // payloads are broadcast, only the valids are steered
    assign mst_aw_o[p]       = aw_i;
    assign mst_aw_valid_o[p] = aw_offer & aw_port_hit[p];
    assign mst_w_o[p]        = w_i;
    assign mst_w_valid_o[p]  = w_valid_i & w_route_ok & w_port_hit[p];
    assign mst_b_ready_o[p]  = ~b_fifo_empty & b_ready_i & b_port_hit[p];
  end

  // ----------------------------------------
  // W channel
  // ----------------------------------------
  // W needs a known target and room to remember it for B
  assign w_route_ok = ~w_fifo_empty & ~b_fifo_full;
  assign w_ready_o  = w_route_ok & |(w_port_hit & mst_w_ready_i);
  assign w_fifo_pop = w_valid_i & w_ready_o;

  select_fifo #(
    .Depth   (MaxTrans)
  ) i_w_sel_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (w_fifo_push),
    .data_i  (aw_select_i),
    .pop_i   (w_fifo_pop),
    .data_o  (w_select),
    .full_o  (w_fifo_full),
    .empty_o (w_fifo_empty)
  );

  // a finished W beat hands its select over to the B side
  select_fifo #(
    .Depth   (MaxTrans)
  ) i_b_sel_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (w_fifo_pop),
    .data_i  (w_select),
    .pop_i   (b_fifo_pop),
    .data_o  (b_select),
    .full_o  (b_fifo_full),
    .empty_o (b_fifo_empty)
  );

  // ----------------------------------------
  // B channel
  // ----------------------------------------
  assign b_valid_o  = ~b_fifo_empty & |(b_port_hit & mst_b_valid_i);
  assign b_fifo_pop = b_valid_o & b_ready_i;

  always_comb begin
    b_o = '0;
    for (int p = 0; p < NumPorts; p++) begin
      if (b_port_hit[p]) begin
        b_o = mst_b_i[p];
      end
    end
  end

endmodule

`default_nettype wire

//--- demux_read_path.sv
/*
  Read half of the AXI4-Lite demux: AR and R.
  ar_select_i must stay stable with ar_valid_i until ar_ready_o.
  Up to MaxTrans reads may be open; R returns in AR issue order.
*/
`default_nettype none

module demux_read_path #(
  parameter int unsigned NumPorts = 3,
  parameter int unsigned MaxTrans = 4
) (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  // upstream
  input  lite_demux_pkg::ar_chan_t                 ar_i,
  input  logic                                     ar_valid_i,
  input  lite_demux_pkg::port_sel_t                ar_select_i,
  output logic                                     ar_ready_o,
  output lite_demux_pkg::r_chan_t                  r_o,
  output logic                                     r_valid_o,
  input  logic                                     r_ready_i,
  // downstream
  output lite_demux_pkg::ar_chan_t [NumPorts-1:0]  mst_ar_o,
  output logic [NumPorts-1:0]                      mst_ar_valid_o,
  input  logic [NumPorts-1:0]                      mst_ar_ready_i,
  input  lite_demux_pkg::r_chan_t [NumPorts-1:0]   mst_r_i,
  input  logic [NumPorts-1:0]                      mst_r_valid_i,
  output logic [NumPorts-1:0]                      mst_r_ready_o
);
  import lite_demux_pkg::*;

  logic                r_fifo_push;
  logic                r_fifo_pop;
  logic                r_fifo_full;
  logic                r_fifo_empty;
  port_sel_t           r_select;
  logic [NumPorts-1:0] ar_port_hit;
  logic [NumPorts-1:0] r_port_hit;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    assign ar_port_hit[p] = (ar_select_i == port_sel_t'(p));
    assign r_port_hit[p]  = (r_select == port_sel_t'(p));

    assign mst_ar_o[p]       = ar_i;
    assign mst_ar_valid_o[p] = ar_valid_i & ~r_fifo_full & ar_port_hit[p];
    assign mst_r_ready_o[p]  = ~r_fifo_empty & r_ready_i & r_port_hit[p];
  end

  // ----------------------------------------
  // AR channel
  // ----------------------------------------
  // a full FIFO holds off new reads
  assign ar_ready_o  = ~r_fifo_full & |(ar_port_hit & mst_ar_ready_i);
  assign r_fifo_push = ar_valid_i & ar_ready_o;

  select_fifo #(
    .Depth   (MaxTrans)
  ) i_r_sel_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (r_fifo_push),
    .data_i  (ar_select_i),
    .pop_i   (r_fifo_pop),
    .data_o  (r_select),
    .full_o  (r_fifo_full),
    .empty_o (r_fifo_empty)
  );

  // ----------------------------------------
  // R channel
  // ----------------------------------------
  // only the port of the oldest open read may answer
  assign r_valid_o  = ~r_fifo_empty & |(r_port_hit & mst_r_valid_i);
  assign r_fifo_pop = r_valid_o & r_ready_i;

  always_comb begin
    r_o = '0;
    for (int p = 0; p < NumPorts; p++) begin
      if (r_port_hit[p]) begin
        r_o = mst_r_i[p];
      end
    end
  end

endmodule

`default_nettype wire

//--- lite_demux_top.sv
/*
  AXI4-Lite demux, one manager port to NumPorts subordinate ports.
  NumPorts is 2 to 4, MaxTrans at least 1.
  All channels are combinational, no spill registers.
*/
`default_nettype none

module lite_demux_top #(
  parameter int unsigned NumPorts = 3,
  parameter int unsigned MaxTrans = 4
) (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  lite_demux_pkg::lite_req_t                 slv_req_i,
  input  lite_demux_pkg::port_sel_t                 slv_aw_select_i,
  input  lite_demux_pkg::port_sel_t                 slv_ar_select_i,
  output lite_demux_pkg::lite_resp_t                slv_resp_o,
  output lite_demux_pkg::lite_req_t [NumPorts-1:0]  mst_reqs_o,
  input  lite_demux_pkg::lite_resp_t [NumPorts-1:0] mst_resps_i
);
  import lite_demux_pkg::*;

  aw_chan_t [NumPorts-1:0] mst_aw;
  logic [NumPorts-1:0]     mst_aw_valid;
  logic [NumPorts-1:0]     mst_aw_ready;
  w_chan_t [NumPorts-1:0]  mst_w;
  logic [NumPorts-1:0]     mst_w_valid;
  logic [NumPorts-1:0]     mst_w_ready;
  b_chan_t [NumPorts-1:0]  mst_b;
  logic [NumPorts-1:0]     mst_b_valid;
  logic [NumPorts-1:0]     mst_b_ready;
  ar_chan_t [NumPorts-1:0] mst_ar;
  logic [NumPorts-1:0]     mst_ar_valid;
  logic [NumPorts-1:0]     mst_ar_ready;
  r_chan_t [NumPorts-1:0]  mst_r;
  logic [NumPorts-1:0]     mst_r_valid;
  logic [NumPorts-1:0]     mst_r_ready;

  // ----------------------------------------
  // pack and unpack the downstream structs
  // ----------------------------------------
  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    assign mst_reqs_o[p].aw       = mst_aw[p];
    assign mst_reqs_o[p].aw_valid = mst_aw_valid[p];
    assign mst_reqs_o[p].w        = mst_w[p];
    assign mst_reqs_o[p].w_valid  = mst_w_valid[p];
    assign mst_reqs_o[p].b_ready  = mst_b_ready[p];
    assign mst_reqs_o[p].ar       = mst_ar[p];
    assign mst_reqs_o[p].ar_valid = mst_ar_valid[p];
    assign mst_reqs_o[p].r_ready  = mst_r_ready[p];

    assign mst_aw_ready[p] = mst_resps_i[p].aw_ready;
    assign mst_w_ready[p]  = mst_resps_i[p].w_ready;
    assign mst_b[p]        = mst_resps_i[p].b;
    assign mst_b_valid[p]  = mst_resps_i[p].b_valid;
    assign mst_ar_ready[p] = mst_resps_i[p].ar_ready;
    assign mst_r[p]        = mst_resps_i[p].r;
    assign mst_r_valid[p]  = mst_resps_i[p].r_valid;
  end

  demux_write_path #(
    .NumPorts       (NumPorts),
    .MaxTrans       (MaxTrans)
  ) i_write_path (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .aw_i           (slv_req_i.aw),
    .aw_valid_i     (slv_req_i.aw_valid),
    .aw_select_i    (slv_aw_select_i),
    .aw_ready_o     (slv_resp_o.aw_ready),
    .w_i            (slv_req_i.w),
    .w_valid_i      (slv_req_i.w_valid),
    .w_ready_o      (slv_resp_o.w_ready),
    .b_o            (slv_resp_o.b),
    .b_valid_o      (slv_resp_o.b_valid),
    .b_ready_i      (slv_req_i.b_ready),
    .mst_aw_o       (mst_aw),
    .mst_aw_valid_o (mst_aw_valid),
    .mst_aw_ready_i (mst_aw_ready),
    .mst_w_o        (mst_w),
    .mst_w_valid_o  (mst_w_valid),
    .mst_w_ready_i  (mst_w_ready),
    .mst_b_i        (mst_b),
    .mst_b_valid_i  (mst_b_valid),
    .mst_b_ready_o  (mst_b_ready)
  );

  demux_read_path #(
    .NumPorts       (NumPorts),
    .MaxTrans       (MaxTrans)
  ) i_read_path (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .ar_i           (slv_req_i.ar),
    .ar_valid_i     (slv_req_i.ar_valid),
    .ar_select_i    (slv_ar_select_i),
    .ar_ready_o     (slv_resp_o.ar_ready),
    .r_o            (slv_resp_o.r),
    .r_valid_o      (slv_resp_o.r_valid),
    .r_ready_i      (slv_req_i.r_ready),
    .mst_ar_o       (mst_ar),
    .mst_ar_valid_o (mst_ar_valid),
    .mst_ar_ready_i (mst_ar_ready),
    .mst_r_i        (mst_r),
    .mst_r_valid_i  (mst_r_valid),
    .mst_r_ready_o  (mst_r_ready)
  );

endmodule

`default_nettype wire

//--- lite_demux_props.sv
/*
  Handshake checks bound into the demux top level.
  Stability is checked on the beats the demux offers to its ports;
  upstream stability is left to the driving manager.
*/
`default_nettype none

module lite_demux_props #(
  parameter int unsigned NumPorts = 3
) (
  input logic                                      clk_i,
  input logic                                      reset_i,
  input lite_demux_pkg::lite_resp_t                slv_resp_i,
  input lite_demux_pkg::lite_req_t [NumPorts-1:0]  mst_reqs_i,
  input lite_demux_pkg::lite_resp_t [NumPorts-1:0] mst_resps_i
);

  logic [NumPorts-1:0] aw_valids;
  logic [NumPorts-1:0] ar_valids;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    assign aw_valids[p] = mst_reqs_i[p].aw_valid;
    assign ar_valids[p] = mst_reqs_i[p].ar_valid;

    // an offered beat stays put until the port takes it
    aw_stable : assert property (@(posedge clk_i) disable iff (reset_i)
      mst_reqs_i[p].aw_valid && !mst_resps_i[p].aw_ready
      |=> mst_reqs_i[p].aw_valid && $stable(mst_reqs_i[p].aw))
      else $error("AW on port %0d changed before it was accepted", p);

    w_stable : assert property (@(posedge clk_i) disable iff (reset_i)
      mst_reqs_i[p].w_valid && !mst_resps_i[p].w_ready
      |=> mst_reqs_i[p].w_valid && $stable(mst_reqs_i[p].w))
      else $error("W on port %0d changed before it was accepted", p);

    ar_stable : assert property (@(posedge clk_i) disable iff (reset_i)
      mst_reqs_i[p].ar_valid && !mst_resps_i[p].ar_ready
      |=> mst_reqs_i[p].ar_valid && $stable(mst_reqs_i[p].ar))
      else $error("AR on port %0d changed before it was accepted", p);
  end

  one_aw : assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(aw_valids))
    else $error("more than one downstream AW valid");

  one_ar : assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(ar_valids))
    else $error("more than one downstream AR valid");

  quiet_in_reset : assert property (@(posedge clk_i)
    reset_i |-> !slv_resp_i.b_valid && !slv_resp_i.r_valid)
    else $error("upstream response valid during reset");

endmodule

bind lite_demux_top lite_demux_props #(
  .NumPorts    (NumPorts)
) i_props (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .slv_resp_i  (slv_resp_o),
  .mst_reqs_i  (mst_reqs_o),
  .mst_resps_i (mst_resps_i)
);

`default_nettype wire

//--- tb_lite_demux.sv
/*
  Testbench for the AXI4-Lite demux with 3 ports and 4 open transactions.
  Upstream traffic is random from a fixed seed. Subordinate port p answers
  a read with the address XOR p * 32'h01010101. Port 2 answers every write
  with SLVERR and the other ports answer with OKAY.
  Every wait gives up after Timeout cycles.
*/
`default_nettype none

module tb_lite_demux;
  import lite_demux_pkg::*;

  localparam int unsigned NumPorts = 3;
  localparam int unsigned MaxTrans = 4;
  localparam int          Timeout  = 2000;
  localparam logic [31:0] Seed     = 32'h9c57a8c6;

  logic                      clk;
  logic                      reset;
  lite_req_t                 slv_req;
  port_sel_t                 aw_sel;
  port_sel_t                 ar_sel;
  lite_resp_t                slv_resp;
  lite_req_t  [NumPorts-1:0] mst_reqs;
  lite_resp_t [NumPorts-1:0] mst_resps;

  // transactions of the running test, in issue order
  aw_chan_t  wr_aw [$];
  w_chan_t   wr_w [$];
  port_sel_t wr_sel [$];
  ar_chan_t  rd_ar [$];
  port_sel_t rd_sel [$];
  int        aw_idx, w_idx, ar_idx, b_cnt, r_cnt;

  // scoreboard and subordinate response queues
  aw_chan_t  exp_aw [NumPorts][$];
  w_chan_t   exp_w [NumPorts][$];
  ar_chan_t  exp_ar [NumPorts][$];
  b_chan_t   exp_b [$];
  r_chan_t   exp_r [$];
  b_chan_t   sub_b [NumPorts][$];
  r_chan_t   sub_r [NumPorts][$];

  logic      hold_resp;
  logic      timed_out;
  string     test_name;
  int        test_errors, errors, tests_run;

  lite_demux_top #(
    .NumPorts        (NumPorts),
    .MaxTrans        (MaxTrans)
  ) uut (
    .clk_i           (clk),
    .reset_i         (reset),
    .slv_req_i       (slv_req),
    .slv_aw_select_i (aw_sel),
    .slv_ar_select_i (ar_sel),
    .slv_resp_o      (slv_resp),
    .mst_reqs_o      (mst_reqs),
    .mst_resps_i     (mst_resps)
  );

  always #4 clk = ~clk;

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_aw(input string what, input aw_chan_t exp, input aw_chan_t act);
    if (act !== exp) begin
      $display("Mismatch in %s, %s: expected %h actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_w(input string what, input w_chan_t exp, input w_chan_t act);
    if (act !== exp) begin
      $display("Mismatch in %s, %s: expected %h actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_ar(input string what, input ar_chan_t exp, input ar_chan_t act);
    if (act !== exp) begin
      $display("Mismatch in %s, %s: expected %h actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_b(input string what, input b_chan_t exp, input b_chan_t act);
    if (act !== exp) begin
      $display("Mismatch in %s, %s: expected %h actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_r(input string what, input r_chan_t exp, input r_chan_t act);
    if (act !== exp) begin
      $display("Mismatch in %s, %s: expected %h actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("Error in %s: %s", test_name, msg);
    test_errors++;
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic gen_traffic(input int n_wr, input int n_rd);
    aw_chan_t  aw;
    w_chan_t   w;
    ar_chan_t  ar;
    b_chan_t   b;
    r_chan_t   r;
    port_sel_t sel;
    wr_aw.delete();
    wr_w.delete();
    wr_sel.delete();
    rd_ar.delete();
    rd_sel.delete();
    aw_idx = 0;
    w_idx  = 0;
    ar_idx = 0;
    b_cnt  = 0;
    r_cnt  = 0;
    for (int i = 0; i < n_wr; i++) begin
      sel     = port_sel_t'($urandom_range(NumPorts - 1, 0));
      aw.addr = $urandom;
      aw.prot = 3'($urandom);
      w.data  = $urandom;
      w.strb  = 4'($urandom);
      b.resp  = (sel == 2'd2) ? RespSlvErr : RespOkay;
      wr_aw.push_back(aw);
      wr_w.push_back(w);
      wr_sel.push_back(sel);
      exp_aw[sel].push_back(aw);
      exp_w[sel].push_back(w);
      exp_b.push_back(b);
    end
    for (int i = 0; i < n_rd; i++) begin
      sel     = port_sel_t'($urandom_range(NumPorts - 1, 0));
      ar.addr = $urandom;
      ar.prot = 3'($urandom);
      r.data  = ar.addr ^ (32'(sel) * 32'h01010101);
      r.resp  = RespOkay;
      rd_ar.push_back(ar);
      rd_sel.push_back(sel);
      exp_ar[sel].push_back(ar);
      exp_r.push_back(r);
    end
  endtask

  // handshakes of the cycle that just ended
  task observe();
    int      p;
    b_chan_t b;
    r_chan_t r;
    for (p = 0; p < NumPorts; p++) begin
      if (mst_resps[p].b_valid && mst_reqs[p].b_ready) begin
        void'(sub_b[p].pop_front());
      end
      if (mst_resps[p].r_valid && mst_reqs[p].r_ready) begin
        void'(sub_r[p].pop_front());
      end
      if (mst_reqs[p].aw_valid && mst_resps[p].aw_ready) begin
        if (exp_aw[p].size() == 0) begin
          report_error($sformatf("AW arrived at port %0d without a request for it", p));
        end else begin
          check_aw($sformatf("AW at port %0d", p), exp_aw[p].pop_front(), mst_reqs[p].aw);
        end
      end
      if (mst_reqs[p].w_valid && mst_resps[p].w_ready) begin
        if (exp_w[p].size() == 0) begin
          report_error($sformatf("W arrived at port %0d without a request for it", p));
        end else begin
          check_w($sformatf("W at port %0d", p), exp_w[p].pop_front(), mst_reqs[p].w);
        end
        b.resp = (p == 2) ? RespSlvErr : RespOkay;
        sub_b[p].push_back(b);
      end
      if (mst_reqs[p].ar_valid && mst_resps[p].ar_ready) begin
        if (exp_ar[p].size() == 0) begin
          report_error($sformatf("AR arrived at port %0d without a request for it", p));
        end else begin
          check_ar($sformatf("AR at port %0d", p), exp_ar[p].pop_front(), mst_reqs[p].ar);
        end
        r.data = mst_reqs[p].ar.addr ^ (32'(p) * 32'h01010101);
        r.resp = RespOkay;
        sub_r[p].push_back(r);
      end
    end
    if (slv_req.aw_valid && slv_resp.aw_ready) aw_idx++;
    if (slv_req.w_valid && slv_resp.w_ready) w_idx++;
    if (slv_req.ar_valid && slv_resp.ar_ready) ar_idx++;
    if (slv_resp.b_valid && slv_req.b_ready) begin
      if (exp_b.size() == 0) report_error("B arrived upstream with no write open");
      else check_b($sformatf("B %0d", b_cnt), exp_b.pop_front(), slv_resp.b);
      b_cnt++;
    end
    if (slv_resp.r_valid && slv_req.r_ready) begin
      if (exp_r.size() == 0) report_error("R arrived upstream with no read open");
      else check_r($sformatf("R %0d", r_cnt), exp_r.pop_front(), slv_resp.r);
      r_cnt++;
    end
  endtask

  // next values for the manager and the subordinates
  task drive();
    int p;
    // an offered beat is held until it transfers
    if (!slv_req.aw_valid || slv_resp.aw_ready) begin
      slv_req.aw_valid <= (aw_idx < wr_aw.size()) && ($urandom_range(3, 0) != 0);
      if (aw_idx < wr_aw.size()) begin
        slv_req.aw <= wr_aw[aw_idx];
        aw_sel     <= wr_sel[aw_idx];
      end
    end
    if (!slv_req.w_valid || slv_resp.w_ready) begin
      slv_req.w_valid <= (w_idx < wr_w.size()) && ($urandom_range(3, 0) != 0);
      if (w_idx < wr_w.size()) slv_req.w <= wr_w[w_idx];
    end
    if (!slv_req.ar_valid || slv_resp.ar_ready) begin
      slv_req.ar_valid <= (ar_idx < rd_ar.size()) && ($urandom_range(3, 0) != 0);
      if (ar_idx < rd_ar.size()) begin
        slv_req.ar <= rd_ar[ar_idx];
        ar_sel     <= rd_sel[ar_idx];
      end
    end
    slv_req.b_ready <= 1'($urandom);
    slv_req.r_ready <= 1'($urandom);
    for (p = 0; p < NumPorts; p++) begin
      mst_resps[p].aw_ready <= ($urandom_range(3, 0) != 0);
      mst_resps[p].w_ready  <= ($urandom_range(3, 0) != 0);
      mst_resps[p].ar_ready <= ($urandom_range(3, 0) != 0);
      if (!mst_resps[p].b_valid || mst_reqs[p].b_ready) begin
        mst_resps[p].b_valid <= (sub_b[p].size() != 0) && !hold_resp && 1'($urandom);
        if (sub_b[p].size() != 0) mst_resps[p].b <= sub_b[p][0];
      end
      if (!mst_resps[p].r_valid || mst_reqs[p].r_ready) begin
        mst_resps[p].r_valid <= (sub_r[p].size() != 0) && !hold_resp && 1'($urandom);
        if (sub_r[p].size() != 0) mst_resps[p].r <= sub_r[p][0];
      end
    end
  endtask

  task step();
    @(posedge clk);
    observe();
    drive();
  endtask

  // ----------------------------------------
  // waits and bookkeeping
  // ----------------------------------------
  task automatic wait_done();
    int cycles;
    cycles = 0;
    while ((b_cnt < wr_aw.size() || r_cnt < rd_ar.size()) && cycles < Timeout) begin
      step();
      cycles++;
    end
    if (b_cnt < wr_aw.size() || r_cnt < rd_ar.size()) begin
      report_error($sformatf("timed out with %0d of %0d writes and %0d of %0d reads done",
                             b_cnt, wr_aw.size(), r_cnt, rd_ar.size()));
      timed_out = 1'b1;
    end
  endtask

  // until the select FIFOs hold as many open transactions as they can
  task automatic wait_filled();
    int cycles;
    cycles = 0;
    while ((w_idx < MaxTrans || ar_idx < MaxTrans || aw_idx < wr_aw.size())
           && cycles < Timeout) begin
      step();
      cycles++;
    end
    if (w_idx < MaxTrans || ar_idx < MaxTrans || aw_idx < wr_aw.size()) begin
      report_error("timed out before the open transactions reached the limit");
      timed_out = 1'b1;
    end
  endtask

  // any downstream valid, or a B or R ready without an open transaction
  function automatic logic any_mst_request();
    logic v;
    v = 1'b0;
    for (int p = 0; p < NumPorts; p++) begin
      v = v | mst_reqs[p].aw_valid | mst_reqs[p].w_valid | mst_reqs[p].ar_valid
            | mst_reqs[p].b_ready | mst_reqs[p].r_ready;
    end
    return v;
  endfunction

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    for (int p = 0; p < NumPorts; p++) begin
      if (exp_aw[p].size() != 0 || exp_w[p].size() != 0 || exp_ar[p].size() != 0) begin
        report_error($sformatf("port %0d did not receive all of its requests", p));
      end
    end
    if (exp_b.size() != 0 || exp_r.size() != 0) begin
      report_error("some responses never came back upstream");
    end
    if (test_errors == 0) $display("test %s: ok", test_name);
    else $display("test %s: %0d errors", test_name, test_errors);
    errors += test_errors;
    tests_run++;
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    void'($urandom(Seed));
    clk       = 1'b0;
    reset     = 1'b1;
    slv_req   = '0;
    aw_sel    = '0;
    ar_sel    = '0;
    mst_resps = '0;
    hold_resp = 1'b0;
    timed_out = 1'b0;
    errors    = 0;
    tests_run = 0;
    aw_idx    = 0;
    w_idx     = 0;
    ar_idx    = 0;
    b_cnt     = 0;
    r_cnt     = 0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // upstream readies toggle at random here, so an open FIFO would show
    start_test("reset");
    repeat (3) begin
      step();
      if (any_mst_request()) begin
        report_error("a downstream valid or ready is high right after reset");
      end
    end
    finish_test();

    // mixed ports, random stalls on every channel
    if (!timed_out) begin
      start_test("traffic");
      gen_traffic(40, 40);
      wait_done();
      finish_test();
    end

    // responses held back until the FIFOs are full
    if (!timed_out) begin
      start_test("backpressure");
      hold_resp = 1'b1;
      gen_traffic(MaxTrans + 2, MaxTrans + 2);
      wait_filled();
      repeat (8) step();
      if (w_idx != MaxTrans || ar_idx != MaxTrans || b_cnt != 0 || r_cnt != 0) begin
        report_error("transfers went past the open transaction limit");
      end
      hold_resp = 1'b0;
      wait_done();
      finish_test();
    end

    $display("tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0 && !timed_out) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
lite_demux_pkg.sv
select_fifo.sv
demux_write_path.sv
demux_read_path.sv
lite_demux_top.sv
lite_demux_props.sv
tb_lite_demux.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the AXI4-Lite demux testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lite_demux -f sources.f -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_lite_demux)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx '>>> PASS' <<< "$output"; then
  exit 0
fi
exit 1
